// ==== verilog/percArithPkg.sv ====
`default_nettype none

package percArithPkg;

	localparam int WordWidth = 16;
	localparam int LongWidth = 32;

	localparam logic signed [LongWidth-1:0] MaxWord = 32'sd32767;
	localparam logic signed [LongWidth-1:0] MinWord = -32'sd32768;

	////////////////////////////// LAR approximation
	localparam logic signed [WordWidth-1:0] Seg1 = 16'sd1299;
	localparam logic signed [WordWidth-1:0] Seg2 = 16'sd1815;
	localparam logic signed [WordWidth-1:0] Seg3 = 16'sd1944;
	localparam logic signed [WordWidth-1:0] A1 = 16'sd4567;
	localparam logic signed [WordWidth-1:0] A2 = 16'sd11776;
	localparam logic signed [WordWidth-1:0] A3 = 16'sd27443;
	localparam logic signed [LongWidth-1:0] LB1 = 32'sd3271557;
	localparam logic signed [LongWidth-1:0] LB2 = 32'sd16357786;
	localparam logic signed [LongWidth-1:0] LB3 = 32'sd46808433;
	localparam int LarShift = 11;

	////////////////////////////// Smoothing hysteresis
	localparam logic signed [WordWidth-1:0] ThreshL1 = -16'sd3562;
	localparam logic signed [WordWidth-1:0] ThreshL2 = -16'sd3116;
	localparam logic signed [WordWidth-1:0] ThreshH1 = 16'sd1336;
	localparam logic signed [WordWidth-1:0] ThreshH2 = 16'sd890;

	////////////////////////////// Gamma values, Q15
	localparam logic signed [WordWidth-1:0] Gamma1Smooth0 = 16'sd32113;
	localparam logic signed [WordWidth-1:0] Gamma1Smooth1 = 16'sd30802;
	localparam logic signed [WordWidth-1:0] Gamma2High = 16'sd22938;
	localparam logic signed [WordWidth-1:0] Gamma2Low = 16'sd13107;
	localparam logic signed [WordWidth-1:0] Gamma2Smooth1 = 16'sd19661;
	localparam logic signed [WordWidth-1:0] Alpha = 16'sd19302;
	localparam logic signed [WordWidth-1:0] Beta = 16'sd1024;

	// Clip a long value into the signed word range
	function automatic logic signed [WordWidth-1:0] satWord(
		input logic signed [LongWidth-1:0] x);
		if (x > MaxWord)
			return WordWidth'(MaxWord);
		else if (x < MinWord)
			return WordWidth'(MinWord);
		return WordWidth'(x);
	endfunction

endpackage

`default_nettype wire

// ==== verilog/frameLayoutPkg.sv ====
`default_nettype none

package frameLayoutPkg;

	// Frame order is rc[0..1], LsfInt[0..9], LsfNew[0..9]
	localparam int RcCount = 2;
	localparam int LsfOrder = 10;
	localparam int FrameWords = RcCount + 2 * LsfOrder;

	localparam int LsfIntFirst = RcCount; // Index 2
	localparam int LsfNewFirst = LsfIntFirst + LsfOrder; // Index 12

	// One gamma pair per subframe
	localparam int Subframes = 2;

	localparam int PosWidth = $clog2(FrameWords);

endpackage

`default_nettype wire

// ==== verilog/wordFifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module wordFifo #(
	parameter int FifoDepth = 4
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic inValid,
	input wire logic signed [percArithPkg::WordWidth-1:0] inData,
	input wire logic pop,
	output logic signed [percArithPkg::WordWidth-1:0] headData,
	output logic notEmpty,
	output logic inCredit
);
	import percArithPkg::*;

	localparam int PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
	localparam int CountWidth = $clog2(FifoDepth + 1);

	logic signed [WordWidth-1:0] mem [FifoDepth];
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [PtrWidth-1:0] nextRd;
	logic [CountWidth-1:0] count;

	function automatic logic [PtrWidth-1:0] advance(input logic [PtrWidth-1:0] ptr);
		return (ptr == PtrWidth'(FifoDepth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign nextRd = pop ? advance(rdPtr) : rdPtr;
	assign notEmpty = (count != '0);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			inCredit <= 1'b0;
		end
		else
		begin
			if (inValid)
				wrPtr <= advance(wrPtr);
			rdPtr <= nextRd;
			count <= count + CountWidth'(inValid) - CountWidth'(pop);
			inCredit <= pop; // One credit back per consumed word
		end
	end

	always_ff @(posedge clk)
	begin
		if (inValid)
			mem[wrPtr] <= inData;
		// Bypass when the incoming word becomes the new head
		headData <= (inValid && wrPtr == nextRd) ? inData : mem[nextRd];
	end

endmodule

`default_nettype wire

// ==== verilog/percVarControl.sv ====
`timescale 1ns/10ps
`default_nettype none

module percVarControl #(
	parameter int OutCredits = 2
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic notEmpty,
	input wire logic outCredit,
	output logic pop,
	output logic rcLoad,
	output logic rcIndex,
	output logic lsfLoad,
	output logic lsfFirst,
	output logic decide,
	output logic subframe,
	output logic emit,
	output logic frameStart,
	output logic outValid
);
	import frameLayoutPkg::*;

	localparam int CreditWidth = $clog2(OutCredits + 1);

	localparam logic [1:0] PhasePop = 2'd0;
	localparam logic [1:0] PhaseDecide = 2'd1;
	localparam logic [1:0] PhaseEmit = 2'd2;
	localparam logic [1:0] PhaseWait = 2'd3;

	logic [1:0] phase;
	logic [PosWidth-1:0] wordPos;
	logic [CreditWidth-1:0] creditCount;
	logic groupEnd;

	////////////////////////////// Word strobes
	assign pop = (phase == PhasePop) && notEmpty;
	assign frameStart = pop && (wordPos == '0);
	assign rcLoad = pop && (wordPos < RcCount);
	assign rcIndex = wordPos[0]; // Only two coefficients
	assign lsfLoad = pop && (wordPos >= RcCount);
	assign lsfFirst = (wordPos == LsfIntFirst) || (wordPos == LsfNewFirst);

	// Last LSF of LsfInt or LsfNew closes a subframe
	assign groupEnd = (wordPos == LsfIntFirst + LsfOrder - 1) ||
		(wordPos == LsfNewFirst + LsfOrder - 1);

	assign decide = (phase == PhaseDecide);
	assign emit = (phase == PhaseEmit);
	assign outValid = (phase == PhaseWait) && (creditCount != '0);

	////////////////////////////// Phase machine
	always_ff @(posedge clk)
	begin
		if (reset)
			phase <= PhasePop;
		else
		begin
			case (phase)
				PhasePop:
				begin
					if (pop && groupEnd)
						phase <= PhaseDecide;
				end
				PhaseDecide:
					phase <= PhaseEmit;
				PhaseEmit:
					phase <= PhaseWait;
				default:
				begin
					if (outValid)
						phase <= PhasePop; // Result accepted, resume popping
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wordPos <= '0;
			subframe <= 1'b0;
		end
		else
		begin
			if (pop)
				wordPos <= (wordPos == PosWidth'(FrameWords - 1)) ? '0 : wordPos + 1'b1;
			if (emit)
				subframe <= (subframe == Subframes - 1) ? 1'b0 : 1'b1;
		end
	end

	// Output credits, spent by outValid and returned by the sink
	always_ff @(posedge clk)
	begin
		if (reset)
			creditCount <= CreditWidth'(OutCredits);
		else
			creditCount <= creditCount + CreditWidth'(outCredit) - CreditWidth'(outValid);
	end

endmodule

`default_nettype wire

// ==== verilog/larTrack.sv ====
`timescale 1ns/10ps
`default_nettype none

module larTrack (
	input wire logic clk,
	input wire logic reset,
	input wire logic rcLoad,
	input wire logic rcIndex,
	input wire logic signed [percArithPkg::WordWidth-1:0] headData,
	output logic signed [percArithPkg::WordWidth-1:0] larInterp0,
	output logic signed [percArithPkg::WordWidth-1:0] larInterp1,
	output logic signed [percArithPkg::WordWidth-1:0] larNew0,
	output logic signed [percArithPkg::WordWidth-1:0] larNew1
);
	import percArithPkg::*;

	logic signed [WordWidth-1:0] rcAbs;
	logic signed [WordWidth-1:0] curRc;
	logic signed [WordWidth-1:0] curHalf;
	logic signed [WordWidth-1:0] slope;
	logic signed [WordWidth-1:0] larMag;
	logic signed [WordWidth-1:0] larValue;
	logic signed [LongWidth-1:0] offset;
	logic signed [LongWidth-1:0] product;
	logic signed [LongWidth-1:0] diffLong;
	logic signed [WordWidth-1:0] larOld0;
	logic signed [WordWidth-1:0] larOld1;

	////////////////////////////// Coefficient to LAR
	always_comb
	begin
		rcAbs = satWord(headData[WordWidth-1] ? -LongWidth'(headData) : LongWidth'(headData));
		curRc = rcAbs >>> 4;
		curHalf = curRc >>> 1;
		if (curRc <= Seg2)
		begin
			slope = A1;
			offset = LB1;
		end
		else if (curRc <= Seg3)
		begin
			slope = A2;
			offset = LB2;
		end
		else
		begin
			slope = A3;
			offset = LB3;
		end
		product = (LongWidth'(curHalf) * LongWidth'(slope)) <<< 1; // Fractional multiply
		diffLong = product - offset;
		larMag = (curRc <= Seg1) ? curRc : WordWidth'(diffLong >>> LarShift);
		larValue = headData[WordWidth-1] ? -larMag : larMag; // Sign restore
	end

	// Old LARs persist from frame to frame
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			larOld0 <= '0;
			larOld1 <= '0;
		end
		else if (rcLoad && rcIndex)
		begin
			larOld0 <= larNew0;
			larOld1 <= larValue;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rcLoad)
		begin
			if (rcIndex)
			begin
				larNew1 <= larValue;
				larInterp0 <= satWord(LongWidth'(larNew0) + LongWidth'(larOld0)) >>> 1;
				larInterp1 <= satWord(LongWidth'(larValue) + LongWidth'(larOld1)) >>> 1;
			end
			else
				larNew0 <= larValue; // First coefficient waits for the second
		end
	end

endmodule

`default_nettype wire

// ==== verilog/smoothDecide.sv ====
`timescale 1ns/10ps
`default_nettype none

module smoothDecide (
	input wire logic clk,
	input wire logic reset,
	input wire logic frameStart,
	input wire logic decide,
	input wire logic subframe,
	input wire logic signed [percArithPkg::WordWidth-1:0] larInterp0,
	input wire logic signed [percArithPkg::WordWidth-1:0] larInterp1,
	input wire logic signed [percArithPkg::WordWidth-1:0] larNew0,
	input wire logic signed [percArithPkg::WordWidth-1:0] larNew1,
	output logic smooth
);
	import percArithPkg::*;

	logic signed [WordWidth-1:0] crit0;
	logic signed [WordWidth-1:0] crit1;

	// Subframe 0 judges the interpolated LARs, subframe 1 the new ones
	assign crit0 = subframe ? larNew0 : larInterp0;
	assign crit1 = subframe ? larNew1 : larInterp1;

	always_ff @(posedge clk)
	begin
		if (reset || frameStart)
			smooth <= 1'b1;
		else if (decide)
		begin
			if (smooth)
			begin
				if ((crit0 < ThreshL1) && (crit1 > ThreshH1))
					smooth <= 1'b0;
			end
			else if ((crit0 > ThreshL2) || (crit1 < ThreshH2))
				smooth <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/lsfMinDistance.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsfMinDistance (
	input wire logic clk,
	input wire logic reset,
	input wire logic lsfLoad,
	input wire logic lsfFirst,
	input wire logic signed [percArithPkg::WordWidth-1:0] headData,
	output logic signed [percArithPkg::WordWidth-1:0] dMin
);
	import percArithPkg::*;

	logic signed [WordWidth-1:0] lsfDouble;
	logic signed [WordWidth-1:0] lsfPrev;
	logic signed [WordWidth-1:0] diff;
	logic haveMin;

	assign lsfDouble = satWord(LongWidth'(headData) <<< 1);
	assign diff = satWord(LongWidth'(lsfDouble) - LongWidth'(lsfPrev));

	// Set once the first difference of a group is in dMin
	always_ff @(posedge clk)
	begin
		if (reset)
			haveMin <= 1'b0;
		else if (lsfLoad)
			haveMin <= !lsfFirst;
	end

	always_ff @(posedge clk)
	begin
		if (lsfLoad)
		begin
			lsfPrev <= lsfDouble;
			if (!lsfFirst && (!haveMin || diff < dMin))
				dMin <= diff;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/gammaCompute.sv ====
`timescale 1ns/10ps
`default_nettype none

module gammaCompute (
	input wire logic clk,
	input wire logic reset,
	input wire logic emit,
	input wire logic smooth,
	input wire logic signed [percArithPkg::WordWidth-1:0] dMin,
	output logic signed [percArithPkg::WordWidth-1:0] gamma1,
	output logic signed [percArithPkg::WordWidth-1:0] gamma2
);
	import percArithPkg::*;

	logic signed [LongWidth-1:0] alphaProd;
	logic signed [WordWidth-1:0] multQ15;
	logic signed [WordWidth-1:0] betaDiff;
	logic signed [WordWidth-1:0] shifted;
	logic signed [WordWidth-1:0] gamma2Clamped;

	////////////////////////////// gamma2 = shl(Beta - Alpha*dMin, 5)
	always_comb
	begin
		alphaProd = LongWidth'(Alpha) * LongWidth'(dMin);
		multQ15 = satWord(alphaProd >>> 15);
		betaDiff = satWord(LongWidth'(Beta) - LongWidth'(multQ15));
		shifted = satWord(LongWidth'(betaDiff) <<< 5);
		if (shifted > Gamma2High)
			gamma2Clamped = Gamma2High;
		else if (shifted < Gamma2Low)
			gamma2Clamped = Gamma2Low;
		else
			gamma2Clamped = shifted;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			gamma1 <= '0;
			gamma2 <= '0;
		end
		else if (emit)
		begin
			gamma1 <= smooth ? Gamma1Smooth1 : Gamma1Smooth0;
			gamma2 <= smooth ? Gamma2Smooth1 : gamma2Clamped; // Fixed pair when smoothing
		end
	end

endmodule

`default_nettype wire

// ==== verilog/percVarTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module percVarTop #(
	parameter int FifoDepth = 4,
	parameter int OutCredits = 2
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic inValid,
	input wire logic signed [percArithPkg::WordWidth-1:0] inData,
	output logic inCredit,
	output logic outValid,
	input wire logic outCredit,
	output logic signed [percArithPkg::WordWidth-1:0] gamma1,
	output logic signed [percArithPkg::WordWidth-1:0] gamma2
);
	import percArithPkg::*;

	logic signed [WordWidth-1:0] headData;
	logic notEmpty;
	logic pop;
	logic rcLoad;
	logic rcIndex;
	logic lsfLoad;
	logic lsfFirst;
	logic decide;
	logic subframe;
	logic emit;
	logic frameStart;
	logic signed [WordWidth-1:0] larInterp0;
	logic signed [WordWidth-1:0] larInterp1;
	logic signed [WordWidth-1:0] larNew0;
	logic signed [WordWidth-1:0] larNew1;
	logic smooth;
	logic signed [WordWidth-1:0] dMin;

	wordFifo #(.FifoDepth(FifoDepth)) wordFifo_inst (
		.clk, .reset, .inValid, .inData, .pop, .headData, .notEmpty, .inCredit
	);

	percVarControl #(.OutCredits(OutCredits)) percVarControl_inst (
		.clk, .reset, .notEmpty, .outCredit, .pop, .rcLoad, .rcIndex, .lsfLoad,
		.lsfFirst, .decide, .subframe, .emit, .frameStart, .outValid
	);

	larTrack larTrack_inst (
		.clk, .reset, .rcLoad, .rcIndex, .headData,
		.larInterp0, .larInterp1, .larNew0, .larNew1
	);

	smoothDecide smoothDecide_inst (
		.clk, .reset, .frameStart, .decide, .subframe,
		.larInterp0, .larInterp1, .larNew0, .larNew1, .smooth
	);

	lsfMinDistance lsfMinDistance_inst (
		.clk, .reset, .lsfLoad, .lsfFirst, .headData, .dMin
	);

	gammaCompute gammaCompute_inst (
		.clk, .reset, .emit, .smooth, .dMin, .gamma1, .gamma2
	);

endmodule

`default_nettype wire

// ==== sim/percVarTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module percVarTb;
	import percArithPkg::*;
	import frameLayoutPkg::*;

	localparam int FifoDepth = 4;
	localparam int OutCredits = 2;
	localparam int LineWords = FrameWords + 2 * Subframes; // Inputs then gamma pairs

	logic clk;
	logic reset;
	logic inValid;
	logic signed [WordWidth-1:0] inData;
	logic inCredit;
	logic outValid;
	logic outCredit;
	logic signed [WordWidth-1:0] gamma1;
	logic signed [WordWidth-1:0] gamma2;

	int fileWords[$];
	int frameCount;
	int wordsSent;
	int creditsBack; // inCredit pulses seen
	int resultCount;
	int outSpent;
	int outReturned; // Credits handed back by the sink
	int outReturnSeen;
	bit loaded;

	percVarTop #(.FifoDepth(FifoDepth), .OutCredits(OutCredits)) percVarTop_inst (
		.clk, .reset, .inValid, .inData, .inCredit, .outValid, .outCredit, .gamma1, .gamma2
	);

	task automatic stopRun(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic checkGamma(input logic signed [WordWidth-1:0] actual,
		input logic signed [WordWidth-1:0] expected, input string name);
		if (actual !== expected)
			stopRun($sformatf("ERR %0t %s got %0d expected %0d", $time, name, actual, expected));
	endtask

	task automatic checkCount(input int actual, input int expected, input string name);
		if (actual != expected)
			stopRun($sformatf("ERR %0t %s got %0d expected %0d", $time, name, actual, expected));
	endtask

	function automatic logic signed [WordWidth-1:0] expectedWord(input int result, input int which);
		return WordWidth'(fileWords[(result / Subframes) * LineWords + FrameWords
			+ (result % Subframes) * 2 + which]);
	endfunction

	task automatic readFrames();
		int fd;
		int value;
		string header;
		fd = $fopen("sim/percVar_input.txt", "r");
		if (fd == 0)
			stopRun("could not open sim/percVar_input.txt");
		void'($fgets(header, fd)); // Two column description lines
		void'($fgets(header, fd));
		while ($fscanf(fd, "%d", value) == 1)
			fileWords.push_back(value);
		$fclose(fd);
		if (fileWords.size() == 0 || fileWords.size() % LineWords != 0)
			stopRun("input file does not hold whole frames");
		frameCount = fileWords.size() / LineWords;
	endtask

	////////////////////////////// Source and sink
	task automatic sendWords();
		for (int f = 0; f < frameCount; f++)
			for (int w = 0; w < FrameWords; w++)
			begin
				inValid = 1'b0;
				if ($urandom % 4 == 0)
					repeat (1 + $urandom % 3) @(negedge clk); // Idle gap
				while (FifoDepth + creditsBack - wordsSent <= 0)
					@(negedge clk);
				inValid = 1'b1;
				inData = WordWidth'(fileWords[f * LineWords + w]);
				wordsSent++;
				@(negedge clk);
			end
		inValid = 1'b0;
	endtask

	task automatic returnCredits();
		forever
		begin
			@(negedge clk);
			outCredit = 1'b0;
			// Slow sink so the output credits run out
			if (outReturned < outSpent && $urandom % 16 == 0)
			begin
				outCredit = 1'b1;
				outReturned++;
			end
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial
	begin
		reset = 1'b1;
		inValid = 1'b0;
		inData = '0;
		outCredit = 1'b0;
		void'($urandom(6));
		readFrames();
		loaded = 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		fork
			sendWords();
			returnCredits();
		join_any
		wait (resultCount == Subframes * frameCount);
		repeat (60) @(posedge clk); // Room for a stray extra result
		checkCount(creditsBack, wordsSent, "inCredit");
		$display("TEST PASS");
		$finish;
	end

	////////////////////////////// Output monitor
	always @(posedge clk)
	begin
		if (inCredit && creditsBack >= wordsSent)
			stopRun("inCredit pulsed with no word outstanding");
		if (inValid && wordsSent - creditsBack > FifoDepth)
			stopRun("source overran the input FIFO");
		if (inCredit)
			creditsBack++;
		if (outValid)
		begin
			if (wordsSent < LsfNewFirst)
				stopRun("outValid rose before a subframe was complete");
			if (OutCredits - outSpent + outReturnSeen <= 0)
				stopRun("outValid rose without an output credit");
			if (resultCount >= Subframes * frameCount)
				stopRun("more results than subframes sent");
			checkGamma(gamma1, expectedWord(resultCount, 0), $sformatf("gamma1[%0d]", resultCount));
			checkGamma(gamma2, expectedWord(resultCount, 1), $sformatf("gamma2[%0d]", resultCount));
			resultCount++;
			outSpent++;
		end
		if (outCredit)
			outReturnSeen++;
	end

	initial
	begin
		wait (loaded);
		repeat (frameCount * FrameWords * 40) @(posedge clk);
		stopRun($sformatf("the run timed out after %0d cycles", frameCount * FrameWords * 40));
	end

endmodule

`default_nettype wire

// ==== sim/percVar_input.txt ====
# rc0 rc1, LsfInt[0..9], LsfNew[0..9], all signed decimal
# then gamma1 gamma2 of subframe 0 and gamma1 gamma2 of subframe 1
-32000 32000 1000 2000 3000 4000 5000 6000 7000 8000 9000 10000 1000 1435 1870 2305 2740 3175 3610 4045 4480 4915 30802 19661 32113 16384
-32000 32000 1000 1050 1100 1150 1200 1250 1300 1350 1400 1450 1000 1350 1700 2050 2400 2750 3100 3450 3800 4150 32113 22938 32113 19584
-30400 30400 1000 2000 3000 4000 5000 6000 7000 8000 9000 10000 1000 2000 3000 4000 5000 6000 7000 8000 9000 10000 30802 19661 30802 19661
-32768 32767 1000 2000 3000 4000 4435 5435 6435 7435 8435 9435 1000 2000 3000 4000 5000 6000 7000 8000 16000 20000 32113 16384 32113 18336
-30400 30400 1000 2000 3000 2950 4000 5000 6000 7000 8000 9000 1000 2000 3000 4000 5000 6000 7000 8000 9000 10000 32113 22938 30802 19661
-16000 16000 1000 2000 3000 4000 5000 6000 7000 8000 9000 10000 1000 2000 3000 4000 5000 6000 7000 8000 9000 10000 30802 19661 30802 19661
-25600 25600 1000 2000 3000 4000 5000 6000 7000 8000 9000 10000 1000 2000 3000 4000 5000 6000 7000 8000 9000 10000 30802 19661 30802 19661
0 0 1000 2000 3000 4000 5000 6000 7000 8000 9000 10000 1000 2000 3000 4000 5000 6000 7000 8000 9000 10000 30802 19661 30802 19661
-32768 32767 1000 1435 1870 2305 2740 3175 3610 4045 4480 4915 1000 2000 3000 4000 5000 6000 7000 8000 9000 10000 30802 19661 32113 13107
-32768 32767 1000 1350 1700 2050 2400 2750 3100 3450 3800 4150 1000 1050 1100 1150 1200 1250 1300 1350 1400 1450 32113 19584 32113 22938
-32000 25600 1000 2000 3000 4000 5000 6000 7000 8000 16000 20000 1000 2000 3000 4000 4435 5435 6435 7435 8435 9435 32113 18336 32113 16384
-32000 16000 1000 2000 3000 4000 5000 6000 7000 8000 9000 10000 1000 1435 1870 2305 2740 3175 3610 4045 4480 4915 32113 13107 32113 16384
-32000 0 1000 2000 3000 4000 5000 6000 7000 8000 9000 10000 1000 2000 3000 4000 5000 6000 7000 8000 9000 10000 30802 19661 30802 19661
-32768 32767 1000 1435 1870 2305 2740 3175 3610 4045 4480 4915 1000 2000 3000 2950 4000 5000 6000 7000 8000 9000 32113 16384 32113 22938
-32768 -16 1000 1350 1700 2050 2400 2750 3100 3450 3800 4150 1000 2000 3000 4000 5000 6000 7000 8000 9000 10000 32113 19584 30802 19661
-32768 32767 1000 1050 1100 1150 1200 1250 1300 1350 1400 1450 1000 2000 3000 4000 5000 6000 7000 8000 16000 20000 32113 22938 32113 18336
16000 -16000 1000 2000 3000 4000 5000 6000 7000 8000 9000 10000 1000 2000 3000 4000 5000 6000 7000 8000 9000 10000 30802 19661 30802 19661
-32000 32000 1000 2000 3000 4000 5000 6000 7000 8000 9000 10000 1000 1350 1700 2050 2400 2750 3100 3450 3800 4150 30802 19661 32113 19584
-32000 32000 1000 2000 3000 4000 4435 5435 6435 7435 8435 9435 1000 1435 1870 2305 2740 3175 3610 4045 4480 4915 32113 16384 32113 16384
-30400 30400 1000 2000 3000 4000 5000 6000 7000 8000 9000 10000 1000 2000 3000 4000 5000 6000 7000 8000 9000 10000 30802 19661 30802 19661

// ==== all.f ====
verilog/percArithPkg.sv
verilog/frameLayoutPkg.sv
verilog/wordFifo.sv
verilog/percVarControl.sv
verilog/larTrack.sv
verilog/smoothDecide.sv
verilog/lsfMinDistance.sv
verilog/gammaCompute.sv
verilog/percVarTop.sv
sim/percVarTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench, then judge the run from its log
verilator --binary --timing -Wno-fatal -f all.f --top-module percVarTb -o percVarSim \
	> build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/percVarSim > sim.log 2>&1
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1
grep -q "TEST PASS" sim.log || exit 1
